//--- common/trace_game_defines.svh
`ifndef TRACE_GAME_DEFINES_SVH
`define TRACE_GAME_DEFINES_SVH

// clock cycles per game second
// kept tiny so a whole game simulates quickly
`define GAME_SEC_CYCLES 8

// dwell per screen kind, in clock cycles
`define GAME_LOGO_CYCLES 40
`define GAME_TRACE_CYCLES 120
`define GAME_MSG_CYCLES 60

// edge of the square tile map
`define GAME_MAP_DIM 16

// tile code left behind by each accepted move
// banner codes use 0..3, so this stays clear of them
`define GAME_TRAIL_TILE 4'hf

// cursor start cell on entry to a tracing screen
// column is always 0
`define GAME_START_ROW 8

`endif

//--- common/trace_game_pkg.sv
package trace_game_pkg;

    // kind of screen being shown
    // the 2-bit value doubles as the banner tile code
    typedef enum logic [1:0] {
        SCREEN_LOGO       = 2'd0,
        SCREEN_TRACE      = 2'd1,
        SCREEN_MESSAGE    = 2'd2,
        SCREEN_SCOREBOARD = 2'd3
    } screen_kind_t;

    // screen number, first screen is 1
    typedef logic [4:0] screen_idx_t;

    // tile map address
    // row in [7:4], column in [3:0]
    typedef logic [7:0] tile_addr_t;

    // one tile code
    typedef logic [3:0] tile_t;

endpackage

//--- rtl/screen_timer.sv
`timescale 1ns/1ps
`include "trace_game_defines.svh"

module screen_timer (
    input  logic                         clock,
    input  logic                         rst,
    input  logic [5:0]                   total_screens,
    output trace_game_pkg::screen_idx_t  curr_screen,
    output trace_game_pkg::screen_kind_t screen_kind,
    output logic                         screen_change,
    output logic [31:0]                  time_out,
    output logic                         end_of_game
);
    import trace_game_pkg::*;

    // dwell lengths per screen kind
    localparam logic [31:0] LOGO_CYCLES  = 32'(`GAME_LOGO_CYCLES);
    localparam logic [31:0] TRACE_CYCLES = 32'(`GAME_TRACE_CYCLES);
    localparam logic [31:0] MSG_CYCLES   = 32'(`GAME_MSG_CYCLES);
    // seconds prescaler length
    localparam logic [31:0] SEC_CYCLES   = 32'(`GAME_SEC_CYCLES);

    logic [31:0] dwell_cnt;
    logic [31:0] dwell_len;
    logic [31:0] sec_cnt;
    logic        at_last;
    logic        dwell_done;

    // last screen reached, >= so a short total_screens still stops
    assign at_last = ({1'b0, curr_screen} >= total_screens);

    // kind from screen number
    // 1 is the logo, even is a trace, odd above 1 is a message
    always_comb begin
        if (at_last) begin
            screen_kind = SCREEN_SCOREBOARD;
        end else if (curr_screen == 5'd1) begin
            screen_kind = SCREEN_LOGO;
        end else if (curr_screen[0] == 1'b0) begin
            screen_kind = SCREEN_TRACE;
        end else begin
            screen_kind = SCREEN_MESSAGE;
        end
    end

    // dwell for the current kind
    always_comb begin
        case (screen_kind)
            SCREEN_LOGO:  dwell_len = LOGO_CYCLES;
            SCREEN_TRACE: dwell_len = TRACE_CYCLES;
            // scoreboard never steps, its dwell is never used
            default:      dwell_len = MSG_CYCLES;
        endcase
    end

    // last cycle of the dwell, held off on the scoreboard
    assign dwell_done = (dwell_cnt == dwell_len - 32'd1) && !at_last;

    // screen stepping
    // screen_change is high in the same cycle as the new number
    always_ff @(posedge clock) begin
        if (rst) begin
            curr_screen   <= 5'd1;
            dwell_cnt     <= '0;
            screen_change <= 1'b0;
        end else begin
            screen_change <= dwell_done;
            if (dwell_done) begin
                curr_screen <= curr_screen + 5'd1;
                dwell_cnt   <= '0;
            end else if (!at_last) begin
                // message screens count too
                dwell_cnt <= dwell_cnt + 32'd1;
            end
        end
    end

    // free running seconds, independent of screens
    always_ff @(posedge clock) begin
        if (rst) begin
            sec_cnt  <= '0;
            time_out <= '0;
        end else if (sec_cnt == SEC_CYCLES - 32'd1) begin
            sec_cnt  <= '0;
            time_out <= time_out + 32'd1;
        end else begin
            sec_cnt <= sec_cnt + 32'd1;
        end
    end

    // sticky, one cycle behind the last screen
    always_ff @(posedge clock) begin
        if (rst) begin
            end_of_game <= 1'b0;
        end else if (at_last) begin
            end_of_game <= 1'b1;
        end
    end

endmodule

//--- rtl/trail_tracker.sv
`timescale 1ns/1ps
`include "trace_game_defines.svh"

module trail_tracker (
    input  logic                         clock,
    input  logic                         rst,
    input  trace_game_pkg::screen_kind_t screen_kind,
    input  logic                         screen_change,
    input  logic                         move_up,
    input  logic                         move_down,
    input  logic                         move_left,
    input  logic                         move_right,
    output logic                         trail_req,
    output trace_game_pkg::tile_addr_t   trail_addr,
    output trace_game_pkg::tile_t        trail_tile,
    input  logic                         trail_gnt,
    output logic [15:0]                  score
);
    import trace_game_pkg::*;

    // map edge index and start cell
    localparam logic [3:0] LAST_IDX  = 4'(`GAME_MAP_DIM - 1);
    localparam logic [3:0] START_ROW = 4'(`GAME_START_ROW);

    logic [3:0] row;
    logic [3:0] col;
    logic [3:0] next_row;
    logic [3:0] next_col;
    logic       move_ok;
    logic       accept;

    // target cell for this cycle's pulse
    // up wins over down, down over left, left over right
    always_comb begin
        next_row = row;
        next_col = col;
        move_ok  = 1'b0;
        if (move_up) begin
            move_ok  = (row != 4'd0);
            next_row = row - 4'd1;
        end else if (move_down) begin
            move_ok  = (row != LAST_IDX);
            next_row = row + 4'd1;
        end else if (move_left) begin
            move_ok  = (col != 4'd0);
            next_col = col - 4'd1;
        end else if (move_right) begin
            move_ok  = (col != LAST_IDX);
            next_col = col + 4'd1;
        end
    end

    // only on a tracing screen, only with no write pending
    // a pulse on the screen change cycle loses to the cursor reset
    assign accept = (screen_kind == SCREEN_TRACE) && !screen_change && !trail_req && move_ok;

    // every trail write carries the same code
    assign trail_tile = tile_t'(`GAME_TRAIL_TILE);

    // cursor
    always_ff @(posedge clock) begin
        if (rst) begin
            row <= START_ROW;
            col <= '0;
        end else if (screen_change && (screen_kind == SCREEN_TRACE)) begin
            row <= START_ROW;
            col <= '0;
        end else if (accept) begin
            row <= next_row;
            col <= next_col;
        end
    end

    // score and the single pending write
    // address is latched so it stays put until the grant
    always_ff @(posedge clock) begin
        if (rst) begin
            score      <= '0;
            trail_req  <= 1'b0;
            trail_addr <= '0;
        end else if (accept) begin
            score      <= score + 16'd1;
            trail_req  <= 1'b1;
            trail_addr <= {next_row, next_col};
        end else if (trail_gnt) begin
            trail_req <= 1'b0;
        end
    end

endmodule

//--- rtl/banner_writer.sv
`timescale 1ns/1ps
`include "trace_game_defines.svh"

module banner_writer (
    input  logic                         clock,
    input  logic                         rst,
    input  trace_game_pkg::screen_kind_t screen_kind,
    input  logic                         screen_change,
    output logic                         banner_req,
    output trace_game_pkg::tile_addr_t   banner_addr,
    output trace_game_pkg::tile_t        banner_tile,
    input  logic                         banner_gnt
);
    import trace_game_pkg::*;

    // banner lives on the top row
    localparam logic [3:0] BANNER_ROW = 4'd0;
    localparam logic [3:0] LAST_COL   = 4'(`GAME_MAP_DIM - 1);

    logic         busy;
    logic [3:0]   col;
    screen_kind_t code;

    // request held for the whole sweep
    assign banner_req  = busy;
    assign banner_addr = {BANNER_ROW, col};
    // kind code widened to a tile
    assign banner_tile = tile_t'({2'b00, code});

    // one column per grant, 16 in a row
    // a new screen change restarts from column 0
    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= 1'b0;
            col  <= '0;
            code <= SCREEN_LOGO;
        end else if (screen_change) begin
            busy <= 1'b1;
            col  <= '0;
            // kind already shows the new screen here
            code <= screen_kind;
        end else if (banner_gnt) begin
            col <= col + 4'd1;
            if (col == LAST_COL) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/tile_arbiter.sv
`timescale 1ns/1ps
`include "trace_game_defines.svh"

module tile_arbiter (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       banner_req,
    input  trace_game_pkg::tile_addr_t banner_addr,
    input  trace_game_pkg::tile_t      banner_tile,
    output logic                       banner_gnt,
    input  logic                       trail_req,
    input  trace_game_pkg::tile_addr_t trail_addr,
    input  trace_game_pkg::tile_t      trail_tile,
    output logic                       trail_gnt,
    input  logic                       disp_req,
    input  trace_game_pkg::tile_addr_t disp_addr,
    output trace_game_pkg::tile_t      disp_data,
    output logic                       disp_valid
);
    import trace_game_pkg::*;

    localparam int DEPTH = `GAME_MAP_DIM * `GAME_MAP_DIM;

    // whole map, blank at power-up
    tile_t mem [DEPTH] = '{default: '0};

    logic disp_gnt;

    // fixed priority, banner then trail then display
    // grants are same-cycle so a held request gets one write per cycle
    assign banner_gnt = banner_req;
    assign trail_gnt  = trail_req && !banner_req;
    // no second read while the previous one is returning
    assign disp_gnt   = disp_req && !banner_req && !trail_req && !disp_valid;

    // write lands at the end of the grant cycle
    always_ff @(posedge clock) begin
        if (banner_gnt) begin
            mem[banner_addr] <= banner_tile;
        end else if (trail_gnt) begin
            mem[trail_addr] <= trail_tile;
        end
    end

    // registered read
    // data and valid one cycle after the grant
    always_ff @(posedge clock) begin
        if (rst) begin
            disp_valid <= 1'b0;
            disp_data  <= '0;
        end else begin
            disp_valid <= disp_gnt;
            if (disp_gnt) begin
                disp_data <= mem[disp_addr];
            end
        end
    end

endmodule

//--- rtl/trace_game_top.sv
`timescale 1ns/1ps

module trace_game_top (
    input  logic                         clock,
    input  logic                         rst,
    input  logic [5:0]                   total_screens,
    input  logic                         move_up,
    input  logic                         move_down,
    input  logic                         move_left,
    input  logic                         move_right,
    input  logic                         disp_req,
    input  trace_game_pkg::tile_addr_t   disp_addr,
    output trace_game_pkg::screen_idx_t  curr_screen,
    output trace_game_pkg::screen_kind_t screen_kind,
    output logic [31:0]                  time_out,
    output logic                         end_of_game,
    output logic [15:0]                  score,
    output trace_game_pkg::tile_t        disp_data,
    output logic                         disp_valid
);
    import trace_game_pkg::*;

    // screen step strobe
    logic       screen_change;
    // trail write port
    logic       trail_req;
    tile_addr_t trail_addr;
    tile_t      trail_tile;
    logic       trail_gnt;
    // banner write port
    logic       banner_req;
    tile_addr_t banner_addr;
    tile_t      banner_tile;
    logic       banner_gnt;

    screen_timer i_screen_timer (
        .clock         (clock),
        .rst           (rst),
        .total_screens (total_screens),
        .curr_screen   (curr_screen),
        .screen_kind   (screen_kind),
        .screen_change (screen_change),
        .time_out      (time_out),
        .end_of_game   (end_of_game)
    );

    trail_tracker i_trail_tracker (
        .clock         (clock),
        .rst           (rst),
        .screen_kind   (screen_kind),
        .screen_change (screen_change),
        .move_up       (move_up),
        .move_down     (move_down),
        .move_left     (move_left),
        .move_right    (move_right),
        .trail_req     (trail_req),
        .trail_addr    (trail_addr),
        .trail_tile    (trail_tile),
        .trail_gnt     (trail_gnt),
        .score         (score)
    );

    banner_writer i_banner_writer (
        .clock         (clock),
        .rst           (rst),
        .screen_kind   (screen_kind),
        .screen_change (screen_change),
        .banner_req    (banner_req),
        .banner_addr   (banner_addr),
        .banner_tile   (banner_tile),
        .banner_gnt    (banner_gnt)
    );

    // single owner of the tile map
    tile_arbiter i_tile_arbiter (
        .clock       (clock),
        .rst         (rst),
        .banner_req  (banner_req),
        .banner_addr (banner_addr),
        .banner_tile (banner_tile),
        .banner_gnt  (banner_gnt),
        .trail_req   (trail_req),
        .trail_addr  (trail_addr),
        .trail_tile  (trail_tile),
        .trail_gnt   (trail_gnt),
        .disp_req    (disp_req),
        .disp_addr   (disp_addr),
        .disp_data   (disp_data),
        .disp_valid  (disp_valid)
    );

endmodule

//--- verification/trace_game_tests.svh
// dwell per screen number
// 1 is the logo, even is a trace, odd above 1 is a message
function automatic int dwell_of(input int scr);
    return (scr == 1) ? `GAME_LOGO_CYCLES :
           (scr % 2 == 0) ? `GAME_TRACE_CYCLES : `GAME_MSG_CYCLES;
endfunction

// banner code expected for a screen number
function automatic int kind_code(input int scr);
    return (scr == TOTAL_SCREENS) ? 3 : (scr == 1) ? 0 : (scr % 2 == 0) ? 1 : 2;
endfunction

// returns on the falling edge where rst drops
task automatic apply_reset();
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
endtask

task automatic wait_for_screen(input int scr);
    int waited;
    waited = 0;
    while (int'(curr_screen) != scr) begin
        @(negedge clock);
        waited++;
        if (waited > GAME_CYCLES) begin
            abort_run("the expected screen was never reached");
        end
    end
endtask

// dir 0 up, 1 down, 2 left, 3 right, held for len cycles
task automatic pulse_move(input int dir, input int len);
    move_up    = (dir == 0);
    move_down  = (dir == 1);
    move_left  = (dir == 2);
    move_right = (dir == 3);
    repeat (len) @(negedge clock);
    {move_up, move_down, move_left, move_right} = 4'b0000;
endtask

// request held until valid, then dropped for one cycle
task automatic read_tile(input tile_addr_t addr, output tile_t data);
    int waited;
    waited    = 0;
    disp_req  = 1'b1;
    disp_addr = addr;
    do begin
        @(negedge clock);
        waited++;
        if (waited > 64) begin
            abort_run("a display read never returned valid data");
        end
    end while (!disp_valid);
    data     = disp_data;
    disp_req = 1'b0;
    @(negedge clock);
endtask

task automatic test_screen_sequence();
    int len;
    apply_reset();
    for (int s = 1; s <= TOTAL_SCREENS; s++) begin
        // last screen watched for a while to see it stay put
        len = (s == TOTAL_SCREENS) ? 20 : dwell_of(s);
        for (int k = 0; k < len; k++) begin
            check_value("curr_screen", 32'(curr_screen), s);
            check_value("screen_kind", 32'(screen_kind), kind_code(s));
            // rises one cycle after the final step, then sticks
            check_value("end_of_game", 32'(end_of_game), 32'(s == TOTAL_SCREENS && k > 0));
            @(negedge clock);
        end
    end
endtask

task automatic test_seconds();
    int gaps [5] = '{1, 7, 8, 30, 100};
    int elapsed;
    apply_reset();
    elapsed = 0;
    foreach (gaps[i]) begin
        repeat (gaps[i]) @(negedge clock);
        elapsed += gaps[i];
        check_value("time_out", time_out, elapsed / `GAME_SEC_CYCLES);
    end
endtask

task automatic test_banner();
    tile_t data;
    apply_reset();
    for (int s = 2; s <= TOTAL_SCREENS; s++) begin
        wait_for_screen(s);
        // sweep of row 0 is over by now
        repeat (20) @(negedge clock);
        for (int c = 0; c < `GAME_MAP_DIM; c++) begin
            read_tile(tile_addr_t'(c), data);
            check_value("banner disp_data", 32'(data), kind_code(s));
        end
    end
endtask

task automatic test_trail_score();
    int row;
    int col;
    int dir;
    int expected_score;
    tile_addr_t visited [$];
    tile_t data;
    apply_reset();
    wait_for_screen(2);
    // banner idle, so each trail write is granted at once
    repeat (20) @(negedge clock);
    row = `GAME_START_ROW;
    col = 0;
    expected_score = 0;
    repeat (16) begin
        dir = $urandom % 4;
        // cursor model, moves off the map are dropped
        if ((dir == 0 && row > 0) || (dir == 1 && row < `GAME_MAP_DIM - 1) ||
            (dir == 2 && col > 0) || (dir == 3 && col < `GAME_MAP_DIM - 1)) begin
            row += int'(dir == 1) - int'(dir == 0);
            col += int'(dir == 3) - int'(dir == 2);
            expected_score++;
            visited.push_back(tile_addr_t'({4'(row), 4'(col)}));
        end
        pulse_move(dir, 1);
        repeat (3) @(negedge clock);
    end
    check_value("score", 32'(score), expected_score);
    foreach (visited[i]) begin
        // row 0 is repainted by the banner at the next screen change
        if (visited[i][7:4] != 4'd0) begin
            read_tile(visited[i], data);
            check_value("trail disp_data", 32'(data), `GAME_TRAIL_TILE);
        end
    end
endtask

task automatic test_move_gating();
    apply_reset();
    // logo screen, moves ignored
    pulse_move(1, 1);
    repeat (3) @(negedge clock);
    pulse_move(3, 1);
    repeat (3) @(negedge clock);
    check_value("score", 32'(score), 0);
    wait_for_screen(2);
    repeat (20) @(negedge clock);
    // cursor in column 0, left would leave the map
    pulse_move(2, 1);
    repeat (3) @(negedge clock);
    check_value("score", 32'(score), 0);
    // back to back, second pulse meets the pending write
    pulse_move(3, 2);
    repeat (3) @(negedge clock);
    check_value("score", 32'(score), 1);
    // message screen, moves ignored again
    wait_for_screen(3);
    pulse_move(0, 1);
    repeat (3) @(negedge clock);
    pulse_move(3, 1);
    repeat (3) @(negedge clock);
    check_value("score", 32'(score), 1);
endtask

//--- verification/trace_game_tb.sv
`timescale 1ns/1ps
`include "trace_game_defines.svh"

module trace_game_tb;
    import trace_game_pkg::*;

    localparam int CLK_PERIOD             = 10;
    localparam int RESET_CYCLES           = 5;
    localparam int TOTAL_SCREENS          = 5;
    localparam int unsigned RAND_SEED     = 32'hb00855ae;
    // one whole game at the default dwell lengths
    localparam int GAME_CYCLES =
        (`GAME_LOGO_CYCLES + `GAME_TRACE_CYCLES + `GAME_MSG_CYCLES) * TOTAL_SCREENS;
    // room for the resets and the display read-backs
    localparam int WATCHDOG_CYCLES = GAME_CYCLES + 1000;

    logic         clock;
    logic         rst;
    logic [5:0]   total_screens;
    logic         move_up;
    logic         move_down;
    logic         move_left;
    logic         move_right;
    logic         disp_req;
    tile_addr_t   disp_addr;
    screen_idx_t  curr_screen;
    screen_kind_t screen_kind;
    logic [31:0]  time_out;
    logic         end_of_game;
    logic [15:0]  score;
    tile_t        disp_data;
    logic         disp_valid;

    trace_game_top i_trace_game_top (
        .clock         (clock),
        .rst           (rst),
        .total_screens (total_screens),
        .move_up       (move_up),
        .move_down     (move_down),
        .move_left     (move_left),
        .move_right    (move_right),
        .disp_req      (disp_req),
        .disp_addr     (disp_addr),
        .curr_screen   (curr_screen),
        .screen_kind   (screen_kind),
        .time_out      (time_out),
        .end_of_game   (end_of_game),
        .score         (score),
        .disp_data     (disp_data),
        .disp_valid    (disp_valid)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] observed,
                               input logic [31:0] expected);
        if (observed !== expected) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, observed, expected);
            abort_run("value mismatch");
        end
    endtask

    `include "trace_game_tests.svh"

    initial begin
        clock         = 1'b0;
        rst           = 1'b1;
        total_screens = 6'(TOTAL_SCREENS);
        move_up       = 1'b0;
        move_down     = 1'b0;
        move_left     = 1'b0;
        move_right    = 1'b0;
        disp_req      = 1'b0;
        disp_addr     = '0;
        void'($urandom(RAND_SEED));
        test_screen_sequence();
        test_seconds();
        test_banner();
        test_trail_score();
        test_move_gating();
        $display("all tests passed");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout: the tests did not finish within the watchdog limit");
    end

endmodule

//--- flist.f
+incdir+common
+incdir+verification
common/trace_game_pkg.sv
rtl/screen_timer.sv
rtl/trail_tracker.sv
rtl/banner_writer.sv
rtl/tile_arbiter.sv
rtl/trace_game_top.sv
verification/trace_game_tb.sv

//--- Bender.yml
package:
  name: trace_game

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/trace_game_pkg.sv
      - rtl/screen_timer.sv
      - rtl/trail_tracker.sv
      - rtl/banner_writer.sv
      - rtl/tile_arbiter.sv
      - rtl/trace_game_top.sv
  - target: simulation
    include_dirs:
      - common
      - verification
    files:
      - verification/trace_game_tb.sv
